// File: cart_bus_top.f
cart_bus_pkg.sv
bus_cycle_if.sv
reg_access_if.sv
bus_sampler.sv
cycle_decoder.sv
sdc_regs.sv
cart_bus_top.sv
tb_cart_bus_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cart bus testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cart_bus_top -f cart_bus_top.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'ALL CHECKS PASSED'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb_cart_bus_top.sv
module tb_cart_bus_top import cart_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS       = 25;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 * FRAME_CYCLES + 16 + 200;

    typedef enum logic [1:0] {
        K_MEM_RD,
        K_MEM_WR,
        K_IO_WR
    } kind_e;

    typedef struct packed {
        kind_e         kind;
        logic          slot;
        logic [15:0]   addr;
        logic [7:0]    data;
        logic [4:0]    ctl;         // rnd, done pulse, busy, timeout, crc
        logic [7:0]    exp_cd;
        logic          exp_dir;
        logic [2:0]    exp_start;   // rstart, wstart, init
        megaram_type_e exp_mr;
        logic          exp_scc;
    } row_t;

    logic          clk108_w         = 1'b0;
    logic          ram_enabled_w    = 1'b0;
    logic [7:0]    mp               = 8'hFF;
    logic [7:0]    cd_in            = 8'hFF;
    logic          rd_n             = 1'b1;
    logic          wr_n             = 1'b1;
    logic          sltsl_n          = 1'b1;
    logic          sd_busy          = 1'b0;
    logic          sd_done          = 1'b0;
    logic          sd_crc_error     = 1'b0;
    logic          sd_timeout_error = 1'b0;
    logic [2:0]    msel_n;
    logic [7:0]    cd_out;
    logic          datadir;
    logic          sd_rstart;
    logic          sd_wstart;
    logic          sd_init;
    megaram_type_e megaram_type;
    logic          scc_enable;

    logic [15:0] cur_addr = 16'h0000;   // host side of the current access
    logic        cur_mem  = 1'b0;
    logic        cur_io   = 1'b0;
    logic [15:0] lfsr_state = 16'd65079;
    row_t        rows [NUM_ROWS];
    int          row_count   = 0;
    int          step        = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;

    cart_bus_top u_dut (
        .clk108_w         (clk108_w),
        .ram_enabled_w    (ram_enabled_w),
        .mp               (mp),
        .cd_in            (cd_in),
        .rd_n             (rd_n),
        .wr_n             (wr_n),
        .sltsl_n          (sltsl_n),
        .msel_n           (msel_n),
        .cd_out           (cd_out),
        .datadir          (datadir),
        .sd_rstart        (sd_rstart),
        .sd_wstart        (sd_wstart),
        .sd_init          (sd_init),
        .sd_busy          (sd_busy),
        .sd_done          (sd_done),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .megaram_type     (megaram_type),
        .scc_enable       (scc_enable)
    );

    always #5 clk108_w = ~clk108_w;

    always @(posedge clk108_w) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, test sequence did not complete", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // host bus model driving mp from the select
    ////////////////////////////////////////////////////////////
    function automatic logic [7:0] ctrl_byte(input logic mem, input logic io);
        logic [7:0] c;
        c = 8'hFF;                  // all flags inactive with m1 high
        c[CTRL_MERQ_BIT] = ~mem;
        c[CTRL_IORQ_BIT] = ~io;
        return c;
    endfunction

    always @(negedge clk108_w) begin
        case (msel_n)
            MSEL_LOW:  mp = cur_addr[7:0];
            MSEL_HIGH: mp = cur_addr[15:8];
            MSEL_CTRL: mp = ctrl_byte(cur_mem, cur_io);
            default:   mp = 8'hFF;
        endcase
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;   // galois taps 16,14,13,11
        end
        return n;
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        for (int k = 0; k < 8; k++) begin
            b[k] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("** Error step %0d %s: got %h expected %h", step, name, got, exp);
        end
    endtask

    task automatic add_row(input kind_e kind, input logic slot, input logic [15:0] addr,
                           input logic [7:0] data, input logic [4:0] ctl,
                           input logic [7:0] cd, input logic dir, input logic [2:0] start,
                           input megaram_type_e mr, input logic scc);
        rows[row_count] = {kind, slot, addr, data, ctl, cd, dir, start, mr, scc};
        row_count = row_count + 1;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////
    // kind, slot, addr, data, ctl | cd_out, datadir, start bits, megaram_type, scc
    task automatic build_table();
        add_row(K_MEM_RD, 1'b1, SDC_STATUS, 8'h00, 5'h06, 8'hFF, 1'b0, 3'b000, MR_KONAMI, 1'b0);
        add_row(K_MEM_WR, 1'b1, SDC_CMD,    8'h81, 5'h00, 8'hFF, 1'b1, 3'b000, MR_KONAMI, 1'b0);
        add_row(K_MEM_WR, 1'b1, SDC_ENABLE, 8'h01, 5'h00, 8'hFF, 1'b1, 3'b000, MR_KONAMI, 1'b0);
        add_row(K_MEM_RD, 1'b1, SDC_ENABLE, 8'h00, 5'h00, 8'h01, 1'b0, 3'b000, MR_KONAMI, 1'b0);
        add_row(K_MEM_RD, 1'b1, SDC_STATUS, 8'h00, 5'h06, 8'h82, 1'b0, 3'b000, MR_KONAMI, 1'b0);
        add_row(K_MEM_RD, 1'b1, SDC_STATUS, 8'h00, 5'h01, 8'h01, 1'b0, 3'b000, MR_KONAMI, 1'b0);
        // sector number bytes with random data
        add_row(K_MEM_WR, 1'b1, 16'h7E03,   8'h00, 5'h10, 8'h01, 1'b1, 3'b000, MR_KONAMI, 1'b0);
        add_row(K_MEM_WR, 1'b1, 16'h7E04,   8'h00, 5'h10, 8'h01, 1'b1, 3'b000, MR_KONAMI, 1'b0);
        add_row(K_MEM_WR, 1'b1, 16'h7E05,   8'h00, 5'h10, 8'h01, 1'b1, 3'b000, MR_KONAMI, 1'b0);
        add_row(K_MEM_WR, 1'b1, 16'h7E06,   8'h00, 5'h10, 8'h01, 1'b1, 3'b000, MR_KONAMI, 1'b0);
        add_row(K_MEM_WR, 1'b1, SDC_CMD,    8'h81, 5'h00, 8'h01, 1'b1, 3'b101, MR_KONAMI, 1'b0);
        add_row(K_IO_WR,  1'b0, 16'h0020,   8'h00, 5'h08, 8'h01, 1'b1, 3'b001, MR_KONAMI, 1'b0);
        add_row(K_MEM_WR, 1'b1, SDC_CMD,    8'h02, 5'h00, 8'h01, 1'b1, 3'b011, MR_KONAMI, 1'b0);
        add_row(K_MEM_WR, 1'b1, SDC_CMD,    8'h01, 5'h08, 8'h01, 1'b1, 3'b001, MR_KONAMI, 1'b0);
        // megaram config port
        add_row(K_IO_WR,  1'b0, 16'h008F,   8'h05, 5'h00, 8'h01, 1'b1, 3'b001, MR_SCCPLUS, 1'b1);
        add_row(K_IO_WR,  1'b0, 16'h008E,   8'h16, 5'h00, 8'h01, 1'b1, 3'b001, MR_SCCPLUS, 1'b1);
        add_row(K_IO_WR,  1'b0, 16'h008F,   8'h16, 5'h00, 8'h01, 1'b1, 3'b001, MR_ASCII16, 1'b0);
        add_row(K_IO_WR,  1'b0, 16'h008F,   8'h08, 5'h00, 8'h01, 1'b1, 3'b001, MR_ASCII8, 1'b0);
        add_row(K_IO_WR,  1'b0, 16'h008F,   8'h00, 5'h10, 8'h01, 1'b1, 3'b001, MR_KONAMI, 1'b0);
        add_row(K_MEM_RD, 1'b0, SDC_STATUS, 8'h00, 5'h00, 8'h01, 1'b1, 3'b001, MR_KONAMI, 1'b0);
        add_row(K_MEM_RD, 1'b1, SDC_END,    8'h00, 5'h00, 8'hFF, 1'b0, 3'b001, MR_KONAMI, 1'b0);
        add_row(K_MEM_RD, 1'b0, SDC_ENABLE, 8'h00, 5'h00, 8'hFF, 1'b1, 3'b001, MR_KONAMI, 1'b0);
        add_row(K_MEM_RD, 1'b1, SDC_ENABLE, 8'h00, 5'h00, 8'h01, 1'b0, 3'b001, MR_KONAMI, 1'b0);
        add_row(K_MEM_WR, 1'b1, SDC_ENABLE, 8'h00, 5'h00, 8'h01, 1'b1, 3'b001, MR_KONAMI, 1'b0);
        add_row(K_MEM_RD, 1'b1, SDC_ENABLE, 8'h00, 5'h00, 8'hFF, 1'b0, 3'b001, MR_KONAMI, 1'b0);
    endtask

    // select order on falling edges with two per code
    task automatic check_msel_sequence();
        logic [2:0] order [4];
        order[0] = MSEL_LOW;
        order[1] = MSEL_HIGH;
        order[2] = MSEL_CTRL;
        order[3] = MSEL_NONE;
        while (msel_n != MSEL_LOW) begin
            @(negedge clk108_w);
        end
        for (int k = 0; k < 2 * FRAME_CYCLES; k++) begin
            check_value("msel_n", 32'(msel_n), 32'(order[(k / 2) % 4]));
            @(negedge clk108_w);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one host access held 3 frames then 1 frame idle
    ////////////////////////////////////////////////////////////
    task automatic run_row(input int i);
        row_t       r;
        logic [7:0] d;
        r = rows[i];
        d = r.data;
        if (r.ctl[4]) begin
            draw_byte(d);
            while (d == CODE_SCCPLUS || d == CODE_ASCII16 || d == CODE_ASCII8) begin
                draw_byte(d);   // keep away from the known codes
            end
        end
        step             = i + 1;
        cur_addr         = r.addr;
        cur_mem          = (r.kind != K_IO_WR);
        cur_io           = (r.kind == K_IO_WR);
        rd_n             = (r.kind != K_MEM_RD);
        wr_n             = (r.kind == K_MEM_RD);
        sltsl_n          = ~r.slot;
        cd_in            = (r.kind == K_MEM_RD) ? 8'hFF : d;  // transceiver toward cart on writes
        sd_busy          = r.ctl[2];
        sd_timeout_error = r.ctl[1];
        sd_crc_error     = r.ctl[0];
        repeat (20) @(negedge clk108_w);
        if (r.ctl[3]) begin
            sd_done = 1'b1;     // mid hold once the first frame acted
            @(negedge clk108_w);
            sd_done = 1'b0;
            repeat (3) @(negedge clk108_w);
        end else begin
            repeat (4) @(negedge clk108_w);
        end
        rd_n = 1'b1;
        wr_n = 1'b1;
        repeat (6) @(negedge clk108_w);
        check_value("cd_out", 32'(cd_out), 32'(r.exp_cd));
        check_value("datadir", 32'(datadir), 32'(r.exp_dir));
        check_value("sd_rstart", 32'(sd_rstart), 32'(r.exp_start[2]));
        check_value("sd_wstart", 32'(sd_wstart), 32'(r.exp_start[1]));
        check_value("sd_init", 32'(sd_init), 32'(r.exp_start[0]));
        check_value("megaram_type", 32'(megaram_type), 32'(r.exp_mr));
        check_value("scc_enable", 32'(scc_enable), 32'(r.exp_scc));
        repeat (2) @(negedge clk108_w);
    endtask

    initial begin
        build_table();
        repeat (16) @(negedge clk108_w);
        ram_enabled_w = 1'b1;
        check_value("datadir", 32'(datadir), 32'h1);
        check_value("sd_rstart", 32'(sd_rstart), 32'h0);
        check_value("sd_wstart", 32'(sd_wstart), 32'h0);
        check_value("sd_init", 32'(sd_init), 32'h0);
        check_value("megaram_type", 32'(megaram_type), 32'(MR_KONAMI));
        check_value("scc_enable", 32'(scc_enable), 32'h0);
        check_msel_sequence();
        while (msel_n != MSEL_NONE) begin
            @(negedge clk108_w);    // rows start between frames
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: cart_bus_top.sv
module cart_bus_top import cart_bus_pkg::*; (
    input  logic          clk108_w,
    input  logic          ram_enabled_w,
    input  logic [7:0]    mp,
    input  logic [7:0]    cd_in,
    input  logic          rd_n,
    input  logic          wr_n,
    input  logic          sltsl_n,
    output logic [2:0]    msel_n,
    output logic [7:0]    cd_out,
    output logic          datadir,
    output logic          sd_rstart,
    output logic          sd_wstart,
    output logic          sd_init,
    input  logic          sd_busy,
    input  logic          sd_done,
    input  logic          sd_crc_error,
    input  logic          sd_timeout_error,
    output megaram_type_e megaram_type,
    output logic          scc_enable
);

    bus_cycle_if  cyc_if ();
    reg_access_if acc_if ();

    // pins -> bus cycle
    bus_sampler u_sampler (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .cd_in         (cd_in),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .msel_n        (msel_n),
        .cyc           (cyc_if.source)
    );

    cycle_decoder u_decoder (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .cyc           (cyc_if.sink),
        .acc           (acc_if.source)
    );

    sdc_regs u_regs (
        .clk108_w         (clk108_w),
        .ram_enabled_w    (ram_enabled_w),
        .acc              (acc_if.sink),
        .sd_busy          (sd_busy),
        .sd_done          (sd_done),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .sd_rstart        (sd_rstart),
        .sd_wstart        (sd_wstart),
        .sd_init          (sd_init),
        .megaram_type     (megaram_type),
        .scc_enable       (scc_enable),
        .cd_out           (cd_out),
        .datadir          (datadir)
    );

endmodule

// File: sdc_regs.sv
module sdc_regs import cart_bus_pkg::*; (
    input  logic              clk108_w,
    input  logic              ram_enabled_w,
    reg_access_if.sink        acc,
    input  logic              sd_busy,
    input  logic              sd_done,
    input  logic              sd_crc_error,
    input  logic              sd_timeout_error,
    output logic              sd_rstart,
    output logic              sd_wstart,
    output logic              sd_init,
    output megaram_type_e     megaram_type,
    output logic              scc_enable,
    output logic [7:0]        cd_out,
    output logic              datadir
);

    logic       ff_sd_en;
    sector_t    ff_sector;
    logic       sd_act_w;
    logic       is_read_w;
    logic [7:0] status_w;
    logic [7:0] rdata_w;

    assign sd_act_w = acc.valid && ff_sd_en;   // sd window open

    ////////////////////////////////////////////////////////////
    // sd control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            ff_sd_en  <= 1'b0;
            sd_rstart <= 1'b0;
            sd_wstart <= 1'b0;
            sd_init   <= 1'b0;
        end else begin
            if (sd_done) begin
                sd_rstart <= 1'b0;
                sd_wstart <= 1'b0;
            end
            if (acc.valid && acc.op == OP_ENABLE_WR) begin
                ff_sd_en <= acc.data[0];
            end
            if (sd_act_w && acc.op == OP_CMD_WR) begin
                sd_rstart <= sd_rstart | acc.data[CMD_RSTART_BIT];  // sticky until done
                sd_wstart <= sd_wstart | acc.data[CMD_WSTART_BIT];
                sd_init   <= sd_init   | acc.data[CMD_INIT_BIT];
            end
        end
    end

    // sector number for the reader
    always_ff @(posedge clk108_w) begin
        if (sd_act_w && acc.op == OP_SECTOR_WR) begin
            ff_sector[8*acc.byte_idx +: 8] <= acc.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // megaram config port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            megaram_type <= MR_KONAMI;
            scc_enable   <= 1'b0;
        end else if (acc.valid && acc.op == OP_MEGARAM_CFG) begin
            scc_enable <= 1'b0;
            case (acc.data)
                CODE_SCCPLUS: begin
                    megaram_type <= MR_SCCPLUS;
                    scc_enable   <= 1'b1;
                end
                CODE_ASCII16: megaram_type <= MR_ASCII16;
                CODE_ASCII8:  megaram_type <= MR_ASCII8;
                default:      megaram_type <= MR_KONAMI;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read data back to host
    ////////////////////////////////////////////////////////////
    assign status_w  = {sd_busy, 5'b0, sd_timeout_error, sd_crc_error};
    assign is_read_w = (acc.op == OP_ENABLE_RD) || (acc.op == OP_STATUS_RD) ||
                       (acc.op == OP_UNMAPPED_RD);

    always_comb begin
        rdata_w = UNMAPPED_BYTE;
        if (ff_sd_en) begin
            case (acc.op)
                OP_ENABLE_RD: rdata_w = {7'b0, ff_sd_en};
                OP_STATUS_RD: rdata_w = status_w;
                default: ;
            endcase
        end
    end

    // datadir low turns the transceiver toward the host
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            cd_out  <= UNMAPPED_BYTE;
            datadir <= 1'b1;
        end else if (acc.valid) begin
            datadir <= ~(is_read_w && acc.slot_sel);
            if (is_read_w) begin
                cd_out <= rdata_w;
            end
        end
    end

endmodule

// File: cycle_decoder.sv
module cycle_decoder import cart_bus_pkg::*; (
    input  logic          clk108_w,
    input  logic          ram_enabled_w,
    bus_cycle_if.sink     cyc,
    reg_access_if.source  acc
);

    reg_op_e   op_next;
    byte_idx_t idx_next;
    logic      slot_mem_w;
    logic      sd_window_w;
    logic      sector_hit_w;

    assign slot_mem_w   = cyc.mem_req && !cyc.io_req && cyc.slot_sel;
    assign sd_window_w  = (cyc.addr >= SDC_SDATA) && (cyc.addr <= SDC_END);
    assign sector_hit_w = (cyc.addr >= SDC_SADDR) && (cyc.addr <= SDC_SADDR + 16'd3);

    ////////////////////////////////////////////////////////////
    // classify by cycle kind, then by address
    ////////////////////////////////////////////////////////////
    always_comb begin
        op_next  = OP_IGNORE;
        idx_next = byte_idx_t'(cyc.addr - SDC_SADDR);  // lane within sector reg
        if (cyc.io_req && cyc.is_write && !cyc.m1 && cyc.addr[7:0] == MEGARAM_PORT) begin
            op_next = OP_MEGARAM_CFG;
        end else if (slot_mem_w && cyc.is_write && sd_window_w) begin
            if (cyc.addr == SDC_ENABLE) begin
                op_next = OP_ENABLE_WR;
            end else if (cyc.addr == SDC_CMD) begin
                op_next = OP_CMD_WR;
            end else if (sector_hit_w) begin
                op_next = OP_SECTOR_WR;
            end
        end else if (slot_mem_w && cyc.is_read) begin
            case (cyc.addr)
                SDC_ENABLE: op_next = OP_ENABLE_RD;
                SDC_STATUS: op_next = OP_STATUS_RD;
                default:    op_next = OP_UNMAPPED_RD;  // slot still answers
            endcase
        end
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            acc.valid <= 1'b0;
        end else begin
            acc.valid <= cyc.valid;
        end
    end

    always_ff @(posedge clk108_w) begin
        if (cyc.valid) begin
            acc.op       <= op_next;
            acc.byte_idx <= idx_next;
            acc.data     <= cyc.data;
            acc.slot_sel <= cyc.slot_sel;
        end
    end

endmodule

// File: bus_sampler.sv
module bus_sampler import cart_bus_pkg::*; (
    input  logic        clk108_w,
    input  logic        ram_enabled_w,
    input  logic [7:0]  mp,
    input  logic [7:0]  cd_in,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        sltsl_n,
    output logic [2:0]  msel_n,
    bus_cycle_if.source cyc
);

    dot_phase_t  ff_phase;
    logic        ff_sample_en;
    logic        ff_ctrl_taken;
    logic        ff_strobe_prev;
    logic        ff_valid;
    logic [7:0]  ff_addr_lo;
    logic [7:0]  ff_addr_hi;
    logic [7:0]  ff_data;
    logic        ff_merq_n;
    logic        ff_iorq_n;
    logic        ff_m1_n;
    logic        ff_rd_n;
    logic        ff_wr_n;
    logic        ff_sltsl_n;
    logic        strobe_w;

    ////////////////////////////////////////////////////////////
    // dot phase and pin mux select
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            ff_phase <= '0;
        end else if (ff_phase == dot_phase_t'(FRAME_CYCLES - 1)) begin
            ff_phase <= '0;
        end else begin
            ff_phase <= ff_phase + 3'd1;
        end
    end

    // select goes out one cycle ahead of its sample
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            msel_n       <= MSEL_NONE;
            ff_sample_en <= 1'b0;
        end else begin
            ff_sample_en <= 1'b0;
            case (ff_phase)
                3'd0: begin
                    msel_n       <= MSEL_LOW;
                    ff_sample_en <= 1'b1;
                end
                3'd2: begin
                    msel_n       <= MSEL_HIGH;
                    ff_sample_en <= 1'b1;
                end
                3'd4: begin
                    msel_n       <= MSEL_CTRL;
                    ff_sample_en <= 1'b1;
                end
                3'd6: msel_n <= MSEL_NONE;
                default: ;
            endcase
        end
    end

    // strobes and data are captured with the control byte
    always_ff @(posedge clk108_w) begin
        if (ff_sample_en) begin
            case (msel_n)
                MSEL_LOW:  ff_addr_lo <= mp;
                MSEL_HIGH: ff_addr_hi <= mp;
                MSEL_CTRL: begin
                    ff_merq_n  <= mp[CTRL_MERQ_BIT];
                    ff_iorq_n  <= mp[CTRL_IORQ_BIT];
                    ff_m1_n    <= mp[CTRL_M1_BIT];
                    ff_data    <= cd_in;
                    ff_rd_n    <= rd_n;
                    ff_wr_n    <= wr_n;
                    ff_sltsl_n <= sltsl_n;
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // one cycle per host access
    ////////////////////////////////////////////////////////////
    assign strobe_w = ~ff_rd_n | ~ff_wr_n;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            ff_ctrl_taken  <= 1'b0;
            ff_strobe_prev <= 1'b0;
            ff_valid       <= 1'b0;
        end else begin
            ff_ctrl_taken <= ff_sample_en && (msel_n == MSEL_CTRL);
            ff_valid      <= 1'b0;
            if (ff_ctrl_taken) begin
                ff_valid       <= strobe_w & ~ff_strobe_prev;  // rising strobe only
                ff_strobe_prev <= strobe_w;
            end
        end
    end

    assign cyc.valid    = ff_valid;
    assign cyc.addr     = {ff_addr_hi, ff_addr_lo};
    assign cyc.data     = ff_data;
    assign cyc.is_read  = ~ff_rd_n;
    assign cyc.is_write = ~ff_wr_n;
    assign cyc.mem_req  = ~ff_merq_n;
    assign cyc.io_req   = ~ff_iorq_n;
    assign cyc.m1       = ~ff_m1_n;
    assign cyc.slot_sel = ~ff_sltsl_n;

endmodule

// File: reg_access_if.sv
// decoded register operation with one pulse per host access
interface reg_access_if import cart_bus_pkg::*; ();

    logic      valid;
    reg_op_e   op;
    byte_idx_t byte_idx;    // sector byte lane
    logic [7:0] data;
    logic      slot_sel;

    modport source (
        output valid, op, byte_idx, data, slot_sel
    );

    modport sink (
        input valid, op, byte_idx, data, slot_sel
    );

endinterface

// File: bus_cycle_if.sv
// one host bus cycle as seen at the end of a frame
interface bus_cycle_if;

    logic        valid;     // first frame of a strobe only
    logic [15:0] addr;
    logic [7:0]  data;
    logic        is_read;
    logic        is_write;
    logic        mem_req;
    logic        io_req;
    logic        m1;
    logic        slot_sel;

    modport source (
        output valid, addr, data, is_read, is_write,
        output mem_req, io_req, m1, slot_sel
    );

    modport sink (
        input valid, addr, data, is_read, is_write,
        input mem_req, io_req, m1, slot_sel
    );

endinterface

// File: cart_bus_pkg.sv
package cart_bus_pkg;

    ////////////////////////////////////////////////////////////
    // bus frame
    ////////////////////////////////////////////////////////////
    typedef logic [2:0] dot_phase_t;

    localparam int FRAME_CYCLES = 8;            // clk108 cycles per frame

    localparam logic [2:0] MSEL_LOW  = 3'b110;  // a0-a7
    localparam logic [2:0] MSEL_HIGH = 3'b101;  // a8-a15
    localparam logic [2:0] MSEL_CTRL = 3'b011;  // merq, iorq, .., m1
    localparam logic [2:0] MSEL_NONE = 3'b111;

    localparam int CTRL_MERQ_BIT = 0;
    localparam int CTRL_IORQ_BIT = 1;
    localparam int CTRL_M1_BIT   = 7;

    ////////////////////////////////////////////////////////////
    // sd register map
    ////////////////////////////////////////////////////////////
    localparam logic [15:0] SDC_SDATA  = 16'h7C00;  // start of sd window
    localparam logic [15:0] SDC_ENABLE = 16'h7E00;
    localparam logic [15:0] SDC_CMD    = 16'h7E01;
    localparam logic [15:0] SDC_STATUS = 16'h7E02;
    localparam logic [15:0] SDC_SADDR  = 16'h7E03;  // 4 bytes lsb first
    localparam logic [15:0] SDC_END    = 16'h7EFF;

    localparam int CMD_RSTART_BIT = 0;
    localparam int CMD_WSTART_BIT = 1;
    localparam int CMD_INIT_BIT   = 7;

    localparam logic [7:0] UNMAPPED_BYTE = 8'hFF;

    typedef logic [31:0] sector_t;
    typedef logic [1:0]  byte_idx_t;

    // megaram config port
    localparam logic [7:0] MEGARAM_PORT  = 8'h8F;
    localparam logic [7:0] CODE_SCCPLUS  = 8'h05;
    localparam logic [7:0] CODE_ASCII16  = 8'h16;
    localparam logic [7:0] CODE_ASCII8   = 8'h08;

    typedef enum logic [1:0] {
        MR_KONAMI,
        MR_SCCPLUS,
        MR_ASCII16,
        MR_ASCII8
    } megaram_type_e;

    typedef enum logic [2:0] {
        OP_ENABLE_WR,
        OP_ENABLE_RD,
        OP_CMD_WR,
        OP_SECTOR_WR,
        OP_STATUS_RD,
        OP_MEGARAM_CFG,
        OP_UNMAPPED_RD,
        OP_IGNORE
    } reg_op_e;

endpackage
